/* hdl/fetch_pkg.sv */
// fetch package, shared widths and the fetch state encoding
package fetch_pkg;

  // program counter, byte address of one 32-bit instruction
  typedef logic [31:0] pc_t;

  // one fetched instruction
  typedef logic [31:0] inst_t;

  // sram byte address, low three bits always zero
  typedef logic [31:0] sram_addr_t;

  // sram read word, two instructions side by side
  // upper half holds the instruction at pc[2] = 1
  typedef logic [63:0] sram_data_t;

  // request tracking in the if stage
  //   FS_IDLE  nothing outstanding
  //   FS_WAIT  request accepted, data still to come
  //   FS_DROP  request accepted, then a redirect made its data stale
  typedef enum logic [1:0] {
    FS_IDLE = 2'd0,
    FS_WAIT = 2'd1,
    FS_DROP = 2'd2
  } fetch_state_e;

endpackage

/* hdl/fetch_pc.sv */
`timescale 1ns/1ns
// fetch program counter, steps by 4 per request or jumps to a branch target
module fetch_pc #(
  parameter fetch_pkg::pc_t PC_RESETVAL = 32'h8000_0000
) (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic                  i_step,       // request accepted, move on
  input  logic                  i_redirect,   // taken branch from decode
  input  fetch_pkg::pc_t        i_target,
  output fetch_pkg::pc_t        o_pc,
  output fetch_pkg::sram_addr_t o_sram_addr
);

  import fetch_pkg::*;

  pc_t pc_q;   // pc of the next request to issue

  // redirect wins over the sequential step
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      pc_q <= PC_RESETVAL;
    end else if (i_redirect) begin
      pc_q <= i_target;
    end else if (i_step) begin
      pc_q <= pc_q + 32'd4;
    end
  end

  assign o_pc = pc_q;

  // sram word is 64 bits wide, so the address is 8-byte aligned
  // pc[2] picks the half later on
  assign o_sram_addr = {pc_q[31:3], 3'b000};

endmodule

/* hdl/fetch_if_stage.sv */
`timescale 1ns/1ns
// fetch if stage, issues inst sram requests and selects the fetched instruction half
module fetch_if_stage #(
  parameter fetch_pkg::pc_t PC_RESETVAL = 32'h8000_0000
) (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  // branch bus from decode
  input  logic                  i_br_stall,
  input  logic                  i_br_taken,
  input  fetch_pkg::pc_t        i_br_target,
  // free slots in the instruction queue
  input  logic [3:0]            i_free,
  // inst sram interface
  output logic                  o_inst_sram_ren,
  output fetch_pkg::sram_addr_t o_inst_sram_addr,
  input  logic                  i_inst_sram_addr_ok,
  input  logic                  i_inst_sram_data_ok,
  input  fetch_pkg::sram_data_t i_inst_sram_rdata,
  // to the instruction queue
  output logic                  o_fs_valid,
  output fetch_pkg::inst_t      o_fs_inst,
  output fetch_pkg::pc_t        o_fs_pc
);

  import fetch_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;
  logic         run_q;        // keeps ren low in the first cycle out of reset
  logic         slot_ok;
  logic         req_ok;
  logic         req_accept;
  pc_t          next_pc;      // pc of the next request
  pc_t          req_pc_q;     // pc of the outstanding request

  // pre-if, decide whether a new request may go out

  // a beat already in flight owns one of the free slots
  assign slot_ok = (state_q == FS_WAIT) ? (i_free > 4'd1) : (i_free != 4'd0);

  // one outstanding request at most, a new one may overlap the returning data
  assign req_ok = (state_q == FS_IDLE) ||
                  ((state_q == FS_WAIT) && i_inst_sram_data_ok);

  // no request while the pc is about to be redirected
  assign o_inst_sram_ren = run_q & ~i_br_stall & ~i_br_taken & req_ok & slot_ok;
  assign req_accept      = o_inst_sram_ren & i_inst_sram_addr_ok;

  // if stage, return the data of the accepted request
  assign o_fs_valid = (state_q == FS_WAIT) & i_inst_sram_data_ok & ~i_br_taken;
  assign o_fs_inst  = req_pc_q[2] ? i_inst_sram_rdata[63:32]  // upper half
                                  : i_inst_sram_rdata[31:0];
  assign o_fs_pc    = req_pc_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      FS_IDLE: begin
        if (req_accept) begin
          state_d = FS_WAIT;
        end
      end
      FS_WAIT: begin
        if (i_inst_sram_data_ok) begin
          state_d = req_accept ? FS_WAIT : FS_IDLE;
        end else if (i_br_taken) begin
          state_d = FS_DROP;   // data still to come is stale
        end
      end
      FS_DROP: begin
        if (i_inst_sram_data_ok) begin
          state_d = FS_IDLE;   // stale data swallowed
        end
      end
      default: begin
        state_d = FS_IDLE;
      end
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state_q <= FS_IDLE;
      run_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      run_q   <= 1'b1;
    end
  end

  // pc travels with the request until its data returns
  always_ff @(posedge i_clk) begin
    if (req_accept) begin
      req_pc_q <= next_pc;
    end
  end

  fetch_pc #(
    .PC_RESETVAL (PC_RESETVAL)
  ) u_pc (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_step      (req_accept),
    .i_redirect  (i_br_taken),
    .i_target    (i_br_target),
    .o_pc        (next_pc),
    .o_sram_addr (o_inst_sram_addr)
  );

endmodule

/* hdl/fetch_inst_queue.sv */
`timescale 1ns/1ns
// fetch instruction queue, small FIFO of instruction and pc pairs toward decode
module fetch_inst_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  logic             i_flush,      // taken branch, drop everything
  // write side from the if stage
  input  logic             i_wr_valid,
  input  fetch_pkg::inst_t i_wr_inst,
  input  fetch_pkg::pc_t   i_wr_pc,
  // read side toward decode
  input  logic             i_rd_ready,
  output logic             o_rd_valid,
  output fetch_pkg::inst_t o_rd_inst,
  output fetch_pkg::pc_t   o_rd_pc,
  output logic [3:0]       o_free
);

  import fetch_pkg::*;

  localparam int PTR_W = $clog2(QUEUE_DEPTH);

  inst_t            inst_mem [QUEUE_DEPTH];
  pc_t              pc_mem   [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [3:0]       count_q;
  logic             rd_en;

  // depth need not be a power of two, so wrap by hand
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign rd_en = o_rd_valid & i_rd_ready;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n || i_flush) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= 4'd0;
    end else begin
      if (i_wr_valid) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (rd_en) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      count_q <= count_q + {3'd0, i_wr_valid} - {3'd0, rd_en};
    end
  end

  // entries themselves, write always lands in a free slot
  always_ff @(posedge i_clk) begin
    if (i_wr_valid) begin
      inst_mem[wr_ptr_q] <= i_wr_inst;
      pc_mem[wr_ptr_q]   <= i_wr_pc;
    end
  end

  assign o_rd_valid = (count_q != 4'd0);
  assign o_rd_inst  = inst_mem[rd_ptr_q];   // held until read
  assign o_rd_pc    = pc_mem[rd_ptr_q];
  assign o_free     = 4'(QUEUE_DEPTH) - count_q;

endmodule

/* hdl/fetch_top.sv */
`timescale 1ns/1ns
// fetch front end top, if stage feeding the instruction queue toward decode
module fetch_top #(
  parameter fetch_pkg::pc_t PC_RESETVAL = 32'h8000_0000,
  parameter int             QUEUE_DEPTH = 4
) (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  // branch bus from decode
  input  logic                  i_br_stall,
  input  logic                  i_br_taken,
  input  fetch_pkg::pc_t        i_br_target,
  // inst sram interface
  output logic                  o_inst_sram_ren,
  output fetch_pkg::sram_addr_t o_inst_sram_addr,
  input  logic                  i_inst_sram_addr_ok,
  input  logic                  i_inst_sram_data_ok,
  input  fetch_pkg::sram_data_t i_inst_sram_rdata,
  // instructions to decode
  output logic                  o_inst_valid,
  output fetch_pkg::inst_t      o_inst,
  output fetch_pkg::pc_t        o_inst_pc,
  input  logic                  i_id_ready
);

  import fetch_pkg::*;

  logic       fs_valid;
  inst_t      fs_inst;
  pc_t        fs_pc;
  logic [3:0] free;   // queue space seen by the request logic

  fetch_if_stage #(
    .PC_RESETVAL         (PC_RESETVAL)
  ) u_if_stage (
    .i_clk               (i_clk),
    .i_rst_n             (i_rst_n),
    .i_br_stall          (i_br_stall),
    .i_br_taken          (i_br_taken),
    .i_br_target         (i_br_target),
    .i_free              (free),
    .o_inst_sram_ren     (o_inst_sram_ren),
    .o_inst_sram_addr    (o_inst_sram_addr),
    .i_inst_sram_addr_ok (i_inst_sram_addr_ok),
    .i_inst_sram_data_ok (i_inst_sram_data_ok),
    .i_inst_sram_rdata   (i_inst_sram_rdata),
    .o_fs_valid          (fs_valid),
    .o_fs_inst           (fs_inst),
    .o_fs_pc             (fs_pc)
  );

  fetch_inst_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_inst_queue (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_flush     (i_br_taken),   // redirect empties the queue at once
    .i_wr_valid  (fs_valid),
    .i_wr_inst   (fs_inst),
    .i_wr_pc     (fs_pc),
    .i_rd_ready  (i_id_ready),
    .o_rd_valid  (o_inst_valid),
    .o_rd_inst   (o_inst),
    .o_rd_pc     (o_inst_pc),
    .o_free      (free)
  );

endmodule

/* tb/fetch_properties.sv */
`timescale 1ns/1ns
// fetch front end handshake checks on the sram and decode sides
module fetch_properties (
  input logic        i_clk,
  input logic        i_rst_n,
  input logic        i_br_taken,
  input logic        o_inst_sram_ren,
  input logic        i_inst_sram_addr_ok,
  input logic        i_inst_sram_data_ok,
  input logic        o_inst_valid,
  input logic [31:0] o_inst,
  input logic [31:0] o_inst_pc,
  input logic        i_id_ready
);

  int   fail_count = 0;
  logic outstanding;   // request accepted, data not back yet

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      outstanding <= 1'b0;
    end else if (o_inst_sram_ren && i_inst_sram_addr_ok) begin
      outstanding <= 1'b1;
    end else if (i_inst_sram_data_ok) begin
      outstanding <= 1'b0;
    end
  end

  ren_low_in_reset: assert property (@(posedge i_clk) !i_rst_n |=> !o_inst_sram_ren)
    else begin
      $error("sram read request raised during reset or right after it");
      fail_count = fail_count + 1;
    end

  beat_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_inst_valid && !i_id_ready && !i_br_taken |=>
      o_inst_valid && $stable(o_inst) && $stable(o_inst_pc))
    else begin
      $error("held instruction beat changed under back-pressure");
      fail_count = fail_count + 1;
    end

  data_after_request: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_inst_sram_data_ok |-> outstanding)
    else begin
      $error("sram data returned with no request outstanding");
      fail_count = fail_count + 1;
    end

  // a second request only overlaps the returning data
  one_outstanding: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_inst_sram_ren && outstanding |-> i_inst_sram_data_ok)
    else begin
      $error("second sram request raised while one is outstanding");
      fail_count = fail_count + 1;
    end

endmodule

bind fetch_top fetch_properties fetch_properties_inst (
  .i_clk               (i_clk),
  .i_rst_n             (i_rst_n),
  .i_br_taken          (i_br_taken),
  .o_inst_sram_ren     (o_inst_sram_ren),
  .i_inst_sram_addr_ok (i_inst_sram_addr_ok),
  .i_inst_sram_data_ok (i_inst_sram_data_ok),
  .o_inst_valid        (o_inst_valid),
  .o_inst              (o_inst),
  .o_inst_pc           (o_inst_pc),
  .i_id_ready          (i_id_ready)
);

/* tb/fetch_tb.sv */
`timescale 1ns/1ns
// fetch front end testbench with sram model, decode consumer and stream checker
module fetch_tb;

  import fetch_pkg::*;

  localparam pc_t PC_RESETVAL = 32'h8000_0000;
  localparam int  QUEUE_DEPTH = 4;
  localparam int  TEST_BEATS  = 32;
  localparam int  NUM_TESTS   = 5;
  localparam int  DRAIN_BEATS = 8;    // extra beats ahead of the redirect test
  localparam int  CYCLE_LIMIT = 20 * (NUM_TESTS * TEST_BEATS + DRAIN_BEATS);

  logic       clk;
  logic       rst_n;
  logic       br_stall;
  logic       br_taken;
  pc_t        br_target;
  logic       sram_ren;
  sram_addr_t sram_addr;
  logic       sram_addr_ok;
  logic       sram_data_ok;
  sram_data_t sram_rdata;
  logic       inst_valid;
  inst_t      inst;
  pc_t        inst_pc;
  logic       id_ready;

  integer     seed = 32'he145827f;
  int         lat_min;        // sram data latency range in cycles
  int         lat_max;
  int         refuse_pct;     // percent chance of addr_ok low
  bit         ready_rand;
  int         hold_low;       // cycles of forced ready low
  int         stall_left;
  bit         br_req;
  pc_t        br_req_target;
  bit         pend;           // sram model holds one request in flight
  int         pend_cnt;
  sram_addr_t pend_addr;
  pc_t        exp_q[$];
  pc_t        next_pc;
  int         checks;
  int         errors;
  int         cycles;

  fetch_top #(
    .PC_RESETVAL         (PC_RESETVAL),
    .QUEUE_DEPTH         (QUEUE_DEPTH)
  ) fetch_top_inst (
    .i_clk               (clk),
    .i_rst_n             (rst_n),
    .i_br_stall          (br_stall),
    .i_br_taken          (br_taken),
    .i_br_target         (br_target),
    .o_inst_sram_ren     (sram_ren),
    .o_inst_sram_addr    (sram_addr),
    .i_inst_sram_addr_ok (sram_addr_ok),
    .i_inst_sram_data_ok (sram_data_ok),
    .i_inst_sram_rdata   (sram_rdata),
    .o_inst_valid        (inst_valid),
    .o_inst              (inst),
    .o_inst_pc           (inst_pc),
    .i_id_ready          (id_ready)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // every address bit shapes the instruction stored at a 4-byte address
  function automatic inst_t mem_inst(input pc_t a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h0000_0013;
  endfunction

  // 64-bit sram word with the lower address in the lower half
  function automatic sram_data_t sram_word(input sram_addr_t a);
    return {mem_inst(a + 32'd4), mem_inst(a)};
  endfunction

  // instruction that the memory holds at pc
  function automatic inst_t expected_inst(input pc_t pc);
    return mem_inst(pc);
  endfunction

  function automatic int rand_below(input int n);
    int unsigned r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  // sram model and decode side drive 1 ns after the rising edge
  always begin
    bit         got_req;
    sram_addr_t req_addr;
    @(negedge clk);
    got_req  = rst_n && sram_ren && sram_addr_ok;
    req_addr = sram_addr;
    @(posedge clk);
    #1;
    sram_data_ok = 1'b0;
    if (got_req) begin
      pend      = 1'b1;
      pend_addr = req_addr;
      pend_cnt  = lat_min + rand_below(lat_max - lat_min + 1);
    end
    if (pend) begin
      pend_cnt = pend_cnt - 1;
      if (pend_cnt == 0) begin
        sram_data_ok = 1'b1;
        sram_rdata   = sram_word(pend_addr);
        pend         = 1'b0;
      end
    end
    sram_addr_ok = (rand_below(100) >= refuse_pct);
    br_taken     = br_req;   // one-cycle pulse
    br_target    = br_req_target;
    br_req       = 1'b0;
    br_stall     = (stall_left > 0);
    if (stall_left > 0) begin
      stall_left = stall_left - 1;
    end
    // no transfer in the redirect cycle
    id_ready = (exp_q.size() > 0) && !br_taken && (hold_low == 0) &&
               (!ready_rand || rand_below(2) == 1);
    if (hold_low > 0) begin
      hold_low = hold_low - 1;
    end
  end

  // compare every transferred beat with the expected stream
  always @(negedge clk) begin
    pc_t exp_pc;
    if (rst_n && inst_valid && id_ready) begin
      if (exp_q.size() == 0) begin
        $display("beat with pc %h at time %0t arrived when none was expected", inst_pc, $time);
        errors = errors + 1;
      end else begin
        exp_pc = exp_q.pop_front();
        checks = checks + 1;
        assert (inst_pc == exp_pc) else begin
          $display("FAIL time=%0t o_inst_pc got=%h exp=%h", $time, inst_pc, exp_pc);
          errors = errors + 1;
        end
        assert (inst == expected_inst(exp_pc)) else begin
          $display("FAIL time=%0t o_inst got=%h exp=%h", $time, inst, expected_inst(exp_pc));
          errors = errors + 1;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, %0d beats never arrived", cycles, exp_q.size());
      $display("TB FAILED");
      $finish;
    end
  end

  // quiet point of the cycle after the drive and the compare
  task automatic step_cycle();
    @(posedge clk);
    #3;
  endtask

  task automatic expect_beats(input int n);
    for (int i = 0; i < n; i++) begin
      exp_q.push_back(next_pc);
      next_pc = next_pc + 32'd4;
    end
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      step_cycle();
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("test %s finished, %0d errors", name, errors - errs_before);
  endtask

  initial begin
    int errs;
    int stall_seen;
    rst_n = 1'b0;
    br_stall = 1'b0;
    br_taken = 1'b0;
    br_target = '0;
    sram_addr_ok = 1'b0;
    sram_data_ok = 1'b0;
    sram_rdata = '0;
    id_ready = 1'b0;
    lat_min = 1;
    lat_max = 1;
    refuse_pct = 0;
    ready_rand = 1'b0;
    hold_low = 0;
    stall_left = 0;
    br_req = 1'b0;
    br_req_target = '0;
    pend = 1'b0;
    pend_cnt = 0;
    pend_addr = '0;
    checks = 0;
    errors = 0;
    cycles = 0;
    stall_seen = 0;
    next_pc = PC_RESETVAL;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;

    errs = errors;
    step_cycle();
    expect_beats(TEST_BEATS);
    wait_drained();
    report_test("sequential fetch", errs);

    errs = errors;
    lat_max = 5;
    refuse_pct = 30;
    expect_beats(TEST_BEATS);
    wait_drained();
    report_test("random latency and addr_ok refusals", errs);

    errs = errors;
    ready_rand = 1'b1;
    hold_low = 20;
    expect_beats(TEST_BEATS);
    wait_drained();
    ready_rand = 1'b0;
    report_test("decode back-pressure", errs);

    // long latency so the redirect lands on an outstanding request
    errs = errors;
    lat_min = 4;
    refuse_pct = 0;
    expect_beats(DRAIN_BEATS);
    wait_drained();
    while (!(pend && pend_cnt >= 2 && inst_valid)) begin
      step_cycle();
    end
    br_req_target = PC_RESETVAL + (pc_t'(rand_below(32'h10000)) << 2);
    br_req = 1'b1;
    exp_q.delete();
    next_pc = br_req_target;
    expect_beats(TEST_BEATS);
    wait_drained();
    lat_min = 1;
    report_test("branch redirect", errs);

    errs = errors;
    stall_left = 10;
    expect_beats(TEST_BEATS);
    while (exp_q.size() != 0 || stall_seen < 10) begin
      step_cycle();
      if (br_stall) begin
        stall_seen = stall_seen + 1;
        assert (!sram_ren) else begin
          $display("FAIL time=%0t o_inst_sram_ren got=%b exp=0", $time, sram_ren);
          errors = errors + 1;
        end
      end
    end
    report_test("branch stall", errs);

    errors = errors + fetch_top_inst.fetch_properties_inst.fail_count;
    $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* filelist.f */
hdl/fetch_pkg.sv
hdl/fetch_pc.sv
hdl/fetch_if_stage.sv
hdl/fetch_inst_queue.sv
hdl/fetch_top.sv
tb/fetch_properties.sv
tb/fetch_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the fetch front end with Verilator and run the testbench
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module fetch_tb -f filelist.f -o fetch_sim \
  || { echo "verilator build failed"; exit 1; }
./obj_dir/fetch_sim | tee /dev/stderr | grep -q "TB PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
